/* hdl/tinyriscv_macros.svh */
// tinyriscv core constants: widths, reset fetch address and the no-op word
`ifndef TINYRISCV_MACROS_SVH
`define TINYRISCV_MACROS_SVH

// ------------------------------
// widths
// ------------------------------
`define XLEN        32  // data and address width
`define REG_ADDR_W  5   // register index width

// ------------------------------
// fetch
// ------------------------------
`define RESET_PC    32'h0000_0000

// addi x0, x0, 0
`define INST_NOP    32'h0000_0013

`endif

/* hdl/tinyriscv_pkg.sv */
// tinyriscv package: word, index, opcode, ALU and branch types and stage payloads
`default_nettype none
`include "tinyriscv_macros.svh"

package tinyriscv_pkg;

    typedef logic [`XLEN-1:0]       word_t;
    typedef logic [`XLEN-1:0]       addr_t;
    typedef logic [`REG_ADDR_W-1:0] reg_idx_t;

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011
    } opcode_e;

    // add must stay zero, a cleared payload is an add
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS2
    } alu_op_e;

    // nine kinds, so four bits
    typedef enum logic [3:0] {
        BR_NONE, BR_JAL, BR_JALR, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
    } br_op_e;

    // ------------------------------
    // stage payloads
    // ------------------------------
    typedef struct packed {
        logic     valid;
        alu_op_e  alu_op;
        br_op_e   br_op;
        word_t    op1;
        word_t    op2;
        word_t    rs1_val;  // raw rs1 for compare and jalr base
        word_t    rs2_val;
        addr_t    pc;
        word_t    imm;      // branch/jump offset
        reg_idx_t rd;
        logic     we;
    } id_ex_t;

    typedef struct packed {
        logic     we;
        reg_idx_t rd;
        word_t    data;
    } wb_t;

endpackage

`default_nettype wire

/* hdl/reg_read_if.sv */
// register file read ports, two addresses out of decode and two data words back
`timescale 1ns/1ns
`default_nettype none

interface reg_read_if;

    tinyriscv_pkg::reg_idx_t raddr1;
    tinyriscv_pkg::reg_idx_t raddr2;
    tinyriscv_pkg::word_t    rdata1;  // already forwarded
    tinyriscv_pkg::word_t    rdata2;

    modport decode_mp (
        output raddr1, raddr2,
        input  rdata1, rdata2
    );

    // answered in the same cycle
    modport regs_mp (
        input  raddr1, raddr2,
        output rdata1, rdata2
    );

endinterface

`default_nettype wire

/* hdl/pipe_reg.sv */
// pipeline stage register, any payload type, frozen while the core is stalled
`timescale 1ns/1ns
`default_nettype none

module pipe_reg import tinyriscv_pkg::*; #(
    parameter type T = wb_t
) (
    input  logic clk,
    input  logic reset_i,
    input  logic hold_i,
    input  T     d_i,
    output T     q_o
);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            q_o <= '0;  // valid and we low
        end else if (!hold_i) begin
            q_o <= d_i;
        end
    end

    // a stalled edge must not move the stage
    a_hold_keeps_q: assert property (
        @(posedge clk) disable iff (reset_i)
        (hold_i && !reset_i) |=> $stable(q_o)
    ) else $error("pipe_reg: payload changed across a stalled edge");

endmodule

`default_nettype wire

/* hdl/fetch.sv */
// instruction fetch: program counter and the fetch/decode register
`timescale 1ns/1ns
`default_nettype none
`include "tinyriscv_macros.svh"

module fetch import tinyriscv_pkg::*; (
    input  logic  clk,
    input  logic  reset_i,
    input  logic  hold_i,
    input  logic  jump_i,
    input  addr_t jump_addr_i,
    input  word_t inst_data_i,
    output addr_t pc_o,
    output word_t inst_o,
    output addr_t inst_addr_o
);

    addr_t pc_q;

    assign pc_o = pc_q;

    // ------------------------------
    // program counter
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q <= `RESET_PC;
        end else if (!hold_i) begin
            pc_q <= jump_i ? jump_addr_i : pc_q + addr_t'(4);
        end
    end

    // fetched word, squashed to a no-op by a redirect
    always_ff @(posedge clk) begin
        if (reset_i) begin
            inst_o <= `INST_NOP;
        end else if (!hold_i) begin
            inst_o <= jump_i ? `INST_NOP : inst_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold_i) begin
            inst_addr_o <= pc_q;  // pc of the word above
        end
    end

endmodule

`default_nettype wire

/* hdl/id.sv */
// instruction decode: field split, immediates and operand selection
`timescale 1ns/1ns
`default_nettype none

module id import tinyriscv_pkg::*; (
    input  word_t                inst_i,
    input  addr_t                inst_addr_i,
    input  logic                 flush_i,
    reg_read_if.decode_mp        rf,
    output id_ex_t               id_ex_o
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       alt;  // inst[30], sub and sra
    reg_idx_t   rd;
    word_t      imm_i;
    word_t      imm_u;
    word_t      imm_b;
    word_t      imm_j;
    logic       we;

    assign opcode = opcode_e'(inst_i[6:0]);
    assign funct3 = inst_i[14:12];
    assign alt    = inst_i[30];
    assign rd     = inst_i[11:7];

    assign rf.raddr1 = inst_i[19:15];
    assign rf.raddr2 = inst_i[24:20];

    // ------------------------------
    // immediates
    // ------------------------------
    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_u = {inst_i[31:12], 12'b0};
    assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                    inst_i[11:8], 1'b0};
    assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                    inst_i[30:21], 1'b0};

    function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic alt_bit,
                                           input logic reg_op);
        case (f3)
            3'b000:  return (reg_op && alt_bit) ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt_bit ? ALU_SRA : ALU_SRL;  // srai too
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    function automatic br_op_e br_decode(input logic [2:0] f3);
        case (f3)
            3'b000:  return BR_EQ;
            3'b001:  return BR_NE;
            3'b100:  return BR_LT;
            3'b101:  return BR_GE;
            3'b110:  return BR_LTU;
            3'b111:  return BR_GEU;
            default: return BR_NONE;  // 010/011 reserved
        endcase
    endfunction

    always_comb begin
        id_ex_o.valid   = !flush_i;
        id_ex_o.alu_op  = ALU_ADD;
        id_ex_o.br_op   = BR_NONE;
        id_ex_o.op1     = '0;
        id_ex_o.op2     = rf.rdata2;
        id_ex_o.rs1_val = rf.rdata1;
        id_ex_o.rs2_val = rf.rdata2;
        id_ex_o.pc      = inst_addr_i;
        id_ex_o.imm     = imm_i;
        id_ex_o.rd      = rd;
        we              = 1'b0;

        case (opcode)
            OP_IMM: begin
                id_ex_o.alu_op = alu_decode(funct3, alt, 1'b0);
                id_ex_o.op1    = rf.rdata1;
                id_ex_o.op2    = imm_i;
                we             = 1'b1;
            end
            OP: begin
                id_ex_o.alu_op = alu_decode(funct3, alt, 1'b1);
                id_ex_o.op1    = rf.rdata1;
                we             = 1'b1;
            end
            LUI: begin
                id_ex_o.alu_op = ALU_PASS2;
                id_ex_o.op2    = imm_u;
                id_ex_o.imm    = imm_u;
                we             = 1'b1;
            end
            AUIPC: begin
                id_ex_o.op1 = inst_addr_i;
                id_ex_o.op2 = imm_u;
                id_ex_o.imm = imm_u;
                we          = 1'b1;
            end
            JAL: begin
                id_ex_o.br_op = BR_JAL;
                id_ex_o.imm   = imm_j;
                we            = 1'b1;
            end
            JALR: begin
                id_ex_o.br_op = BR_JALR;  // base comes from rs1_val
                we            = 1'b1;
            end
            BRANCH: begin
                id_ex_o.br_op = br_decode(funct3);
                id_ex_o.imm   = imm_b;
            end
            default: ;  // anything else runs as a no-op
        endcase

        if (rd == '0) begin
            we = 1'b0;
        end
        // bubble behind a redirect
        if (flush_i) begin
            we            = 1'b0;
            id_ex_o.br_op = BR_NONE;
        end
        id_ex_o.we = we;
    end

endmodule

`default_nettype wire

/* hdl/ex.sv */
// execute: ALU, branch compare and jump target
`timescale 1ns/1ns
`default_nettype none

module ex import tinyriscv_pkg::*; (
    input  id_ex_t id_ex_i,
    output wb_t    result_o,
    output logic   jump_o,
    output addr_t  jump_addr_o
);

    word_t      op1;
    word_t      op2;
    word_t      rs1;
    word_t      rs2;
    logic [4:0] shamt;
    word_t      alu_res;
    logic       link;     // jal/jalr write pc+4
    addr_t      jalr_sum;

    assign op1   = id_ex_i.op1;
    assign op2   = id_ex_i.op2;
    assign rs1   = id_ex_i.rs1_val;
    assign rs2   = id_ex_i.rs2_val;
    assign shamt = op2[4:0];

    // ------------------------------
    // ALU
    // ------------------------------
    always_comb begin
        case (id_ex_i.alu_op)
            ALU_ADD:   alu_res = op1 + op2;
            ALU_SUB:   alu_res = op1 - op2;
            ALU_SLL:   alu_res = op1 << shamt;
            ALU_SLT:   alu_res = word_t'($signed(op1) < $signed(op2));
            ALU_SLTU:  alu_res = word_t'(op1 < op2);
            ALU_XOR:   alu_res = op1 ^ op2;
            ALU_SRL:   alu_res = op1 >> shamt;
            ALU_SRA:   alu_res = word_t'($signed(op1) >>> shamt);
            ALU_OR:    alu_res = op1 | op2;
            ALU_AND:   alu_res = op1 & op2;
            ALU_PASS2: alu_res = op2;  // lui
            default:   alu_res = '0;
        endcase
    end

    // ------------------------------
    // branches and jumps
    // ------------------------------
    always_comb begin
        case (id_ex_i.br_op)
            BR_JAL, BR_JALR: jump_o = 1'b1;
            BR_EQ:   jump_o = (rs1 == rs2);
            BR_NE:   jump_o = (rs1 != rs2);
            BR_LT:   jump_o = ($signed(rs1) < $signed(rs2));
            BR_GE:   jump_o = ($signed(rs1) >= $signed(rs2));
            BR_LTU:  jump_o = (rs1 < rs2);
            BR_GEU:  jump_o = (rs1 >= rs2);
            default: jump_o = 1'b0;
        endcase
        // decode must hand over bubbles with no branch kind
        a_no_jump_from_bubble: assert (!jump_o || id_ex_i.valid)
            else $error("ex: redirect raised by an invalid payload");
    end

    assign jalr_sum    = rs1 + id_ex_i.imm;
    assign jump_addr_o = (id_ex_i.br_op == BR_JALR) ? {jalr_sum[31:1], 1'b0}
                                                    : id_ex_i.pc + id_ex_i.imm;

    assign link = (id_ex_i.br_op == BR_JAL) || (id_ex_i.br_op == BR_JALR);

    always_comb begin
        result_o.we   = id_ex_i.valid && id_ex_i.we;
        result_o.rd   = id_ex_i.rd;
        result_o.data = link ? id_ex_i.pc + word_t'(4) : alu_res;
    end

endmodule

`default_nettype wire

/* hdl/regs.sv */
// general purpose register file with operand forwarding and a debug read port
`timescale 1ns/1ns
`default_nettype none

module regs import tinyriscv_pkg::*; (
    input  logic          clk,
    input  logic          reset_i,
    reg_read_if.regs_mp   rf,
    input  wb_t           ex_fwd_i,
    input  wb_t           mem_fwd_i,
    input  wb_t           wb_i,
    input  reg_idx_t      jtag_reg_addr_i,
    output word_t         jtag_reg_data_o
);

    localparam int NREGS = 2 ** $bits(reg_idx_t);

    word_t regs_q [NREGS];  // entry 0 is never written

    // youngest result wins, the write port gives write-through
    function automatic word_t resolve(input reg_idx_t idx, input word_t stored,
                                      input wb_t ex_r, input wb_t mem_r, input wb_t wb_r);
        word_t val;
        if (ex_r.we && ex_r.rd == idx) begin
            val = ex_r.data;
        end else if (mem_r.we && mem_r.rd == idx) begin
            val = mem_r.data;
        end else if (wb_r.we && wb_r.rd == idx) begin
            val = wb_r.data;
        end else begin
            val = stored;
        end
        return val;
    endfunction

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < NREGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wb_i.we && wb_i.rd != '0) begin
            regs_q[wb_i.rd] <= wb_i.data;
        end
    end

    assign rf.rdata1 = resolve(rf.raddr1, regs_q[rf.raddr1], ex_fwd_i, mem_fwd_i, wb_i);
    assign rf.rdata2 = resolve(rf.raddr2, regs_q[rf.raddr2], ex_fwd_i, mem_fwd_i, wb_i);

    // debug read, sees the write in flight
    assign jtag_reg_data_o = (wb_i.we && wb_i.rd != '0 && wb_i.rd == jtag_reg_addr_i)
                           ? wb_i.data : regs_q[jtag_reg_addr_i];

    // x0 stays zero only if no stage ever carries a write to it
    a_x0_reads_zero: assert property (
        @(posedge clk) disable iff (reset_i)
        (rf.raddr1 != '0 || rf.rdata1 == '0) && (rf.raddr2 != '0 || rf.rdata2 == '0)
    ) else $error("regs: read of x0 returned non-zero");

endmodule

`default_nettype wire

/* hdl/tinyriscv.sv */
// tinyriscv core top: fetch, decode, execute and two result stages
`timescale 1ns/1ns
`default_nettype none

module tinyriscv import tinyriscv_pkg::*; (
    input  logic     clk,
    input  logic     reset_i,
    input  logic     hold_i,           // bus hold or debug halt
    output addr_t    rib_pc_addr_o,
    input  word_t    rib_pc_data_i,
    input  reg_idx_t jtag_reg_addr_i,
    output word_t    jtag_reg_data_o
);

    word_t  if_inst;
    addr_t  if_inst_addr;
    id_ex_t id_payload;
    id_ex_t ex_payload;
    wb_t    ex_result;
    wb_t    ex_mem_q;
    wb_t    mem_wb_q;     // register file write port
    logic   ex_jump;
    addr_t  ex_jump_addr;

    reg_read_if rf_if ();

    fetch u_fetch (
        .clk         (clk),
        .reset_i     (reset_i),
        .hold_i      (hold_i),
        .jump_i      (ex_jump),
        .jump_addr_i (ex_jump_addr),
        .inst_data_i (rib_pc_data_i),
        .pc_o        (rib_pc_addr_o),
        .inst_o      (if_inst),
        .inst_addr_o (if_inst_addr)
    );

    id u_id (
        .inst_i      (if_inst),
        .inst_addr_i (if_inst_addr),
        .flush_i     (ex_jump),
        .rf          (rf_if.decode_mp),
        .id_ex_o     (id_payload)
    );

    pipe_reg #(.T(id_ex_t)) u_id_ex (
        .clk     (clk),
        .reset_i (reset_i),
        .hold_i  (hold_i),
        .d_i     (id_payload),
        .q_o     (ex_payload)
    );

    ex u_ex (
        .id_ex_i     (ex_payload),
        .result_o    (ex_result),
        .jump_o      (ex_jump),
        .jump_addr_o (ex_jump_addr)
    );

    // ------------------------------
    // result stages
    // ------------------------------
    pipe_reg #(.T(wb_t)) u_ex_mem (
        .clk     (clk),
        .reset_i (reset_i),
        .hold_i  (hold_i),
        .d_i     (ex_result),
        .q_o     (ex_mem_q)
    );

    pipe_reg #(.T(wb_t)) u_mem_wb (
        .clk     (clk),
        .reset_i (reset_i),
        .hold_i  (hold_i),
        .d_i     (ex_mem_q),
        .q_o     (mem_wb_q)
    );

    regs u_regs (
        .clk             (clk),
        .reset_i         (reset_i),
        .rf              (rf_if.regs_mp),
        .ex_fwd_i        (ex_result),
        .mem_fwd_i       (ex_mem_q),
        .wb_i            (mem_wb_q),
        .jtag_reg_addr_i (jtag_reg_addr_i),
        .jtag_reg_data_o (jtag_reg_data_o)
    );

endmodule

`default_nettype wire

/* bench/inst_rom.sv */
// instruction memory model, combinational word read, unmapped addresses read as a no-op
`timescale 1ns/1ns
`default_nettype none
`include "tinyriscv_macros.svh"

module inst_rom import tinyriscv_pkg::*; #(
    parameter int DEPTH = 64
) (
    input  addr_t addr_i,
    output word_t data_o
);

    word_t words [DEPTH];  // filled by the testbench before each reset

    // only aligned addresses inside the array are mapped
    assign data_o = (addr_i < addr_t'(DEPTH * 4) && addr_i[1:0] == 2'b00)
                  ? words[addr_i[$clog2(DEPTH)+1:2]] : `INST_NOP;

endmodule

`default_nettype wire

/* bench/tinyriscv_tb.sv */
// directed testbench for the tinyriscv core: forwarding, branches, jumps, stall and reset
`timescale 1ns/1ns
`default_nettype none
`include "tinyriscv_macros.svh"

module tinyriscv_tb import tinyriscv_pkg::*; ();

    localparam int CLK_PERIOD  = 10;
    localparam int ROM_WORDS   = 64;
    localparam int RUN_CYCLES  = 30;   // longest program plus pipeline drain
    localparam int HOLD_CYCLES = 5;
    localparam int RUN_COUNT   = 1 + 1 + 12 + 1 + 6 + 1;  // program runs over all tests
    localparam int RUN_BUDGET  = 3 + RUN_CYCLES + HOLD_CYCLES + 32;
    localparam int TIMEOUT_CYCLES = RUN_COUNT * RUN_BUDGET + 100;

    logic     clk;
    logic     reset;
    logic     hold;
    addr_t    rom_addr;
    word_t    rom_data;
    reg_idx_t dbg_addr;
    word_t    dbg_data;

    integer seed;
    int     errors;
    int     test_errors;
    int     checks;
    int     tests_run;
    int     n_words;        // next free program slot
    word_t  exp_regs [32];  // expected x0..x31 after a run

    inst_rom #(.DEPTH(ROM_WORDS)) u_rom (
        .addr_i (rom_addr),
        .data_o (rom_data)
    );

    tinyriscv DUT (
        .clk             (clk),
        .reset_i         (reset),
        .hold_i          (hold),
        .rib_pc_addr_o   (rom_addr),
        .rib_pc_data_i   (rom_data),
        .jtag_reg_addr_i (dbg_addr),
        .jtag_reg_data_o (dbg_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ------------------------------
    // instruction encoders
    // ------------------------------
    function automatic word_t i_type(input word_t imm, input int rs1, input int f3,
                                     input int rd, input logic [6:0] opc);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic word_t r_type(input int f7, input int rs2, input int rs1,
                                     input int f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OP};
    endfunction

    function automatic word_t u_type(input word_t imm, input int rd, input logic [6:0] opc);
        return {imm[19:0], rd[4:0], opc};
    endfunction

    function automatic word_t b_type(input word_t off, input int rs2, input int rs1,
                                     input int f3);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], BRANCH};
    endfunction

    function automatic word_t j_type(input word_t off, input int rd);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], JAL};
    endfunction

    function automatic word_t sext12(input word_t v);
        return {{20{v[11]}}, v[11:0]};
    endfunction

    // RV32I branch conditions by funct3
    function automatic logic branch_taken(input int f3, input word_t a, input word_t b);
        case (f3)
            0:       return a == b;
            1:       return a != b;
            4:       return $signed(a) < $signed(b);
            5:       return $signed(a) >= $signed(b);
            6:       return a < b;
            default: return a >= b;
        endcase
    endfunction

    // ------------------------------
    // program and run helpers
    // ------------------------------
    task automatic clear_program();
        for (int i = 0; i < ROM_WORDS; i++) u_rom.words[i] = `INST_NOP;
        for (int r = 0; r < 32; r++) exp_regs[r] = '0;
        n_words = 0;
    endtask

    task automatic emit(input word_t w);
        u_rom.words[n_words] = w;
        n_words++;
    endtask

    // lui + addi, upper part rounded for the sign of the low twelve bits
    task automatic load_const(input int rd, input word_t value);
        emit(u_type((value + 32'h800) >> 12, rd, LUI));
        emit(i_type(value, rd, 0, rd, OP_IMM));
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        reset = 1'b1;
        hold  = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        checks++;
        assert (got === exp) else begin
            $display("error %0t ns: %s is %h, expected %h", $time, what, got, exp);
            test_errors++;
        end
    endtask

    task automatic compare_regs();
        for (int r = 0; r < 32; r++) begin
            @(posedge clk);
            #1;
            dbg_addr = reg_idx_t'(r);
            #4;
            check_word(dbg_data, exp_regs[r], $sformatf("x%0d", r));
        end
    endtask

    // freeze the core, then read back every register
    task automatic finish_run(input int cycles);
        repeat (cycles) @(posedge clk);
        #1;
        hold = 1'b1;
        compare_regs();
    endtask

    task automatic run_program();
        apply_reset();
        finish_run(RUN_CYCLES);
    endtask

    task automatic report_test(input string name);
        $display("%-20s %0d errors", name, test_errors);
        errors += test_errors;
        test_errors = 0;
        tests_run++;
    endtask

    // ------------------------------
    // tests
    // ------------------------------
    task automatic alu_chain();
        word_t u, a, b, sh, x1, x2, x3, x4;
        u  = $random(seed);
        a  = $random(seed);
        b  = $random(seed);
        sh = $random(seed) & 31;
        clear_program();
        emit(u_type(u, 1, LUI));
        emit(i_type(a, 1, 0, 1, OP_IMM));          // x1 from execute
        emit(i_type(b, 0, 0, 2, OP_IMM));
        emit(r_type(0, 2, 1, 0, 3));               // x1 from ex_mem, x2 from execute
        emit(r_type('h20, 1, 3, 0, 4));
        emit(i_type(sh, 4, 1, 5, OP_IMM));         // slli
        emit(i_type(sh | 32'h400, 3, 5, 6, OP_IMM)); // srai
        emit(r_type(0, 2, 3, 5, 7));               // srl
        emit(r_type('h20, 2, 1, 5, 8));            // sra
        emit(r_type(0, 2, 1, 2, 9));               // slt
        emit(r_type(0, 2, 1, 3, 10));              // sltu
        emit(r_type(0, 4, 3, 4, 11));
        emit(r_type(0, 1, 11, 6, 12));
        emit(i_type(a, 12, 7, 13, OP_IMM));        // andi
        emit(i_type(b, 1, 2, 14, OP_IMM));         // slti
        emit(i_type(b, 1, 3, 15, OP_IMM));         // sltiu
        emit(r_type(0, 2, 1, 1, 16));              // sll
        x1 = {u[19:0], 12'b0} + sext12(a);
        x2 = sext12(b);
        x3 = x1 + x2;
        x4 = x3 - x1;
        exp_regs[1]  = x1;
        exp_regs[2]  = x2;
        exp_regs[3]  = x3;
        exp_regs[4]  = x4;
        exp_regs[5]  = x4 << sh[4:0];
        exp_regs[6]  = $signed(x3) >>> sh[4:0];
        exp_regs[7]  = x3 >> x2[4:0];
        exp_regs[8]  = $signed(x1) >>> x2[4:0];
        exp_regs[9]  = {31'b0, $signed(x1) < $signed(x2)};
        exp_regs[10] = {31'b0, x1 < x2};
        exp_regs[11] = x3 ^ x4;
        exp_regs[12] = (x3 ^ x4) | x1;
        exp_regs[13] = ((x3 ^ x4) | x1) & sext12(a);
        exp_regs[14] = {31'b0, $signed(x1) < $signed(sext12(b))};
        exp_regs[15] = {31'b0, x1 < sext12(b)};
        exp_regs[16] = x1 << x2[4:0];
        run_program();
        report_test("alu_chain");
    endtask

    task automatic writeback_distance();
        word_t a, b;
        a = $random(seed);
        b = $random(seed);
        clear_program();
        emit(i_type(a, 0, 0, 1, OP_IMM));
        emit(`INST_NOP);
        emit(`INST_NOP);
        emit(r_type(0, 1, 1, 0, 2));       // three behind, write port path
        emit(i_type(b, 0, 0, 0, OP_IMM));  // write to x0 is dropped
        emit(r_type(0, 0, 1, 0, 3));
        emit(`INST_NOP);
        emit(r_type(0, 2, 0, 0, 4));       // x2 from the array
        emit(r_type('h20, 2, 3, 0, 5));
        exp_regs[1] = sext12(a);
        exp_regs[2] = sext12(a) + sext12(a);
        exp_regs[3] = sext12(a);
        exp_regs[4] = sext12(a) + sext12(a);
        exp_regs[5] = sext12(a) - (sext12(a) + sext12(a));
        run_program();
        report_test("writeback_distance");
    endtask

    task automatic branch_kinds();
        int    kinds [6] = '{0, 1, 4, 5, 6, 7};  // beq bne blt bge bltu bgeu
        word_t a, b;
        logic  taken;
        for (int k = 0; k < 12; k++) begin
            a = $random(seed);
            b = (k % 2 == 0) ? a : $random(seed);  // equal operands first
            taken = branch_taken(kinds[k / 2], a, b);
            clear_program();
            load_const(1, a);
            load_const(2, b);
            emit(b_type(12, 2, 1, kinds[k / 2]));
            emit(i_type(1, 3, 0, 3, OP_IMM));  // marker, squashed when taken
            emit(i_type(1, 3, 0, 3, OP_IMM));
            emit(i_type(1, 0, 0, 4, OP_IMM));  // branch target
            exp_regs[1] = a;
            exp_regs[2] = b;
            exp_regs[3] = taken ? 32'd0 : 32'd2;
            exp_regs[4] = 32'd1;
            run_program();
        end
        report_test("branch_kinds");
    endtask

    // auipc, jal over two words, jalr with an odd offset, auipc at the target
    task automatic load_jump_program();
        word_t u1, u2;
        u1 = $random(seed);
        u2 = $random(seed);
        clear_program();
        emit(u_type(u1, 1, AUIPC));              // pc 0
        emit(j_type(12, 2));                     // pc 4, to 16
        emit(i_type(1, 0, 0, 5, OP_IMM));
        emit(i_type(1, 0, 0, 5, OP_IMM));
        emit(i_type(40, 0, 0, 3, OP_IMM));       // pc 16
        emit(i_type(1, 3, 0, 4, JALR));          // pc 20, to 40
        for (int i = 0; i < 4; i++) emit(i_type(1, 5, 0, 5, OP_IMM));
        emit(u_type(u2, 6, AUIPC));              // pc 40
        emit(i_type(3, 0, 0, 7, OP_IMM));
        exp_regs[1] = {u1[19:0], 12'b0};
        exp_regs[2] = 32'd8;
        exp_regs[3] = 32'd40;
        exp_regs[4] = 32'd24;
        exp_regs[6] = 32'd40 + {u2[19:0], 12'b0};
        exp_regs[7] = 32'd3;
    endtask

    task automatic jump_link();
        load_jump_program();
        run_program();
        report_test("jump_link");
    endtask

    task automatic stall_replay();
        addr_t held_pc;
        for (int s = 2; s < 8; s++) begin
            load_jump_program();
            apply_reset();
            repeat (s) @(posedge clk);
            #1;
            hold = 1'b1;
            held_pc = rom_addr;
            repeat (HOLD_CYCLES) begin
                @(posedge clk);
                #1;
                check_word(rom_addr, held_pc, "fetch address under stall");
            end
            hold = 1'b0;
            finish_run(RUN_CYCLES - s);
        end
        report_test("stall_replay");
    endtask

    task automatic reset_state();
        clear_program();
        apply_reset();
        hold = 1'b1;  // keep the core parked at the reset address
        check_word(rom_addr, `RESET_PC, "fetch address after reset");
        compare_regs();
        report_test("reset_state");
    endtask

    // ------------------------------
    // main sequence and watchdog
    // ------------------------------
    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        hold        = 1'b0;
        dbg_addr    = '0;
        seed        = 32'hf843_af9a;
        errors      = 0;
        test_errors = 0;
        checks      = 0;
        tests_run   = 0;
        n_words     = 0;
        alu_chain();
        writeback_distance();
        branch_kinds();
        jump_link();
        stall_replay();
        reset_state();
        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* tinyriscv.f */
+incdir+hdl
hdl/tinyriscv_pkg.sv
hdl/reg_read_if.sv
hdl/pipe_reg.sv
hdl/fetch.sv
hdl/id.sv
hdl/ex.sv
hdl/regs.sv
hdl/tinyriscv.sv
bench/inst_rom.sv
bench/tinyriscv_tb.sv

/* Makefile */
# Verilator build and run of the tinyriscv testbench
# override from the command line, e.g. make run FLAGS=--trace-depth

CC       = verilator
TOP      = tinyriscv_tb
FLAGS   ?=
FILELIST = tinyriscv.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
SOURCES  = $(wildcard hdl/*.sv hdl/*.svh bench/*.sv)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(OBJ_DIR)/V%: $(SOURCES) $(FILELIST)
	$(CC) --binary --timing --assert --timescale 1ns/1ns --top-module $* \
		-f $(FILELIST) --Mdir $(OBJ_DIR) $(FLAGS)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
		echo "$$out" | grep -qx "Simulation completed successfully"

clean:
	rm -rf $(OBJ_DIR)
